// ==== field_extractor.sv ====
module field_extractor import parser_pkg::*; (
    input  logic               axis_clk,
    input  logic               aresetn,
    input  logic [HDR_W-1:0]   hdr_i,
    input  logic [ACT_W-1:0]   action_i,
    input  logic               extract_i,
    output logic [VAL_W-1:0]   val_o,
    output kind_e              kind_o,
    output logic [IDX_W-1:0]   index_o
);

    logic [OFF_W-1:0]  offset;
    kind_e             kind;
    logic [HDR_W-1:0]  shifted;
    logic [VAL_W-1:0]  field;

    assign offset = action_i[OFF_W-1:0];
    assign kind   = kind_e'(action_i[KIND_LSB +: KIND_W]);

    // zero fill covers bytes past the end of the header
    assign shifted = hdr_i >> {offset, 3'b000};

    always_comb begin
        case (kind)
            KIND_2B: field = VAL_W'(shifted[W2B-1:0]);
            KIND_4B: field = VAL_W'(shifted[W4B-1:0]);
            KIND_6B: field = shifted[W6B-1:0];
            default: field = '0;
        endcase
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            val_o   <= '0;
            kind_o  <= KIND_NONE;
            index_o <= '0;
        end else if (extract_i) begin
            val_o   <= field;
            kind_o  <= kind;
            index_o <= action_i[IDX_LSB +: IDX_W];
        end
    end

endmodule

// ==== hdr_capture.sv ====
module hdr_capture import parser_pkg::*; (
    input  logic               axis_clk,
    input  logic               aresetn,
    input  logic [DATA_W-1:0]  s_axis_tdata_i,
    input  logic               s_axis_tvalid_i,
    input  logic               s_axis_tlast_i,
    output logic               pkt_start_o,
    output logic [HDR_W-1:0]   hdr_o,
    output logic [VLAN_W-1:0]  vlan_id_o
);

    localparam int CNT_W = $clog2(SEG_NUM + 1);

    logic              tvalid_q;
    logic [CNT_W-1:0]  beat_cnt;
    logic              seg_open;

    // first beat: valid now, idle the cycle before
    assign pkt_start_o = s_axis_tvalid_i & ~tvalid_q;

    // counter saturates at SEG_NUM once the buffer is full
    assign seg_open = s_axis_tvalid_i && (beat_cnt < CNT_W'(SEG_NUM));

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            tvalid_q  <= 1'b0;
            beat_cnt  <= CNT_W'(SEG_NUM);
            vlan_id_o <= '0;
        end else begin
            tvalid_q <= s_axis_tvalid_i;
            if (pkt_start_o) begin
                beat_cnt  <= CNT_W'(1);
                vlan_id_o <= s_axis_tdata_i[VLAN_LSB +: VLAN_W];
            end else if (seg_open) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // beat n lands in segment n of the buffer
    always_ff @(posedge axis_clk) begin
        if (pkt_start_o) begin
            hdr_o[DATA_W-1:0] <= s_axis_tdata_i;
            // single beat packet leaves nothing stale above it
            if (s_axis_tlast_i) begin
                hdr_o[HDR_W-1:DATA_W] <= '0;
            end
        end else if (seg_open) begin
            hdr_o[beat_cnt*DATA_W +: DATA_W] <= s_axis_tdata_i;
        end
    end

endmodule

// ==== parse_act_ram.sv ====
module parse_act_ram import parser_pkg::*; (
    input  logic                axis_clk,
    input  logic                aresetn,
    input  logic                wr_en_i,
    input  logic [TBL_AW-1:0]   wr_addr_i,
    input  logic [ENTRY_W-1:0]  wr_data_i,
    input  logic [TBL_AW-1:0]   rd_addr_i,
    output logic [ENTRY_W-1:0]  rd_data_o
);

    logic [ENTRY_W-1:0] mem [TBL_DEPTH];

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < TBL_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_data_o <= '0;
        end else begin
            if (wr_en_i) begin
                mem[wr_addr_i] <= wr_data_i;
            end
            // old data on a same-cycle address hit
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// ==== parse_ctrl.sv ====
module parse_ctrl import parser_pkg::*; #(
    parameter logic [2:0] PARSER_ID = 3'd0
) (
    input  logic                axis_clk,
    input  logic                aresetn,

    input  logic [DATA_W-1:0]   c_s_axis_tdata_i,
    input  logic [USER_W-1:0]   c_s_axis_tuser_i,
    input  logic [KEEP_W-1:0]   c_s_axis_tkeep_i,
    input  logic                c_s_axis_tvalid_i,
    input  logic                c_s_axis_tlast_i,

    output logic [DATA_W-1:0]   c_m_axis_tdata_o,
    output logic [USER_W-1:0]   c_m_axis_tuser_o,
    output logic [KEEP_W-1:0]   c_m_axis_tkeep_o,
    output logic                c_m_axis_tvalid_o,
    output logic                c_m_axis_tlast_o,

    output logic                tbl_wr_en_o,
    output logic [TBL_AW-1:0]   tbl_wr_addr_o,
    output logic [ENTRY_W-1:0]  tbl_wr_data_o
);

    typedef enum logic [1:0] {
        C_IDLE,
        C_FIRST_WR,
        C_NEXT_WR
    } state_e;

    state_e                    state;
    logic [MOD_ID_W-1:0]       mod_id;
    logic [CTRL_FLAG_W-1:0]    ctrl_flag;
    logic [CTRL_INDEX_W-1:0]   start_idx;
    logic                      cfg_hit;
    logic [ENTRY_W-1:0]        entry_swap;

    assign mod_id    = c_s_axis_tdata_i[MOD_ID_LSB +: MOD_ID_W];
    assign ctrl_flag = c_s_axis_tdata_i[CTRL_FLAG_LSB +: CTRL_FLAG_W];
    assign start_idx = c_s_axis_tdata_i[CTRL_INDEX_LSB +: CTRL_INDEX_W];
    assign cfg_hit   = c_s_axis_tvalid_i && (ctrl_flag == CTRL_FLAG)
                       && (mod_id[2:0] == PARSER_ID);

    // byte 0 of the beat becomes the top byte of the entry
    always_comb begin
        for (int b = 0; b < ENTRY_W / 8; b++) begin
            entry_swap[ENTRY_W-1-8*b -: 8] = c_s_axis_tdata_i[8*b +: 8];
        end
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state             <= C_IDLE;
            tbl_wr_en_o       <= 1'b0;
            tbl_wr_addr_o     <= '0;
            c_m_axis_tdata_o  <= '0;
            c_m_axis_tuser_o  <= '0;
            c_m_axis_tkeep_o  <= '0;
            c_m_axis_tvalid_o <= 1'b0;
            c_m_axis_tlast_o  <= 1'b0;
        end else begin
            tbl_wr_en_o <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (cfg_hit) begin
                        tbl_wr_addr_o     <= start_idx[TBL_AW-1:0];
                        c_m_axis_tvalid_o <= 1'b0;
                        c_m_axis_tlast_o  <= 1'b0;
                        state             <= C_FIRST_WR;
                    end else begin
                        // pass everything else through, idle cycles too
                        c_m_axis_tdata_o  <= c_s_axis_tdata_i;
                        c_m_axis_tuser_o  <= c_s_axis_tuser_i;
                        c_m_axis_tkeep_o  <= c_s_axis_tkeep_i;
                        c_m_axis_tvalid_o <= c_s_axis_tvalid_i;
                        c_m_axis_tlast_o  <= c_s_axis_tlast_i;
                    end
                end
                C_FIRST_WR, C_NEXT_WR: begin
                    c_m_axis_tvalid_o <= 1'b0;
                    c_m_axis_tlast_o  <= 1'b0;
                    if (c_s_axis_tvalid_i) begin
                        tbl_wr_en_o <= 1'b1;
                        if (state == C_NEXT_WR) begin
                            tbl_wr_addr_o <= tbl_wr_addr_o + 1'b1;
                        end
                        state <= c_s_axis_tlast_i ? C_IDLE : C_NEXT_WR;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (state != C_IDLE && c_s_axis_tvalid_i) begin
            tbl_wr_data_o <= entry_swap;
        end
    end

endmodule

// ==== parser.f ====
parser_pkg.sv
hdr_capture.sv
parse_act_ram.sv
parse_ctrl.sv
field_extractor.sv
phv_builder.sv
parser_top.sv
parser_sva.sv
tb_parser.sv

// ==== parser_pkg.sv ====
package parser_pkg;

    // stream widths
    localparam int DATA_W = 512;
    localparam int KEEP_W = DATA_W / 8;
    localparam int USER_W = 128;

    // header buffer
    localparam int SEG_NUM   = 2;
    localparam int HDR_W     = SEG_NUM * DATA_W;
    localparam int HDR_BYTES = HDR_W / 8;

    // vlan id in the first beat
    localparam int VLAN_LSB = 116;
    localparam int VLAN_W   = 12;

    // parse action: offset, container kind, container index
    localparam int ACT_W    = 16;
    localparam int OFF_W    = $clog2(HDR_BYTES);
    localparam int KIND_LSB = OFF_W;
    localparam int KIND_W   = 2;
    localparam int NUM_CONT = 8;
    localparam int IDX_LSB  = KIND_LSB + KIND_W;
    localparam int IDX_W    = $clog2(NUM_CONT);

    // table entry, slot 0 in the top ACT_W bits
    localparam int NUM_SLOTS    = 10;
    localparam int ENTRY_W      = NUM_SLOTS * ACT_W;
    localparam int TBL_DEPTH    = 16;
    localparam int TBL_AW       = $clog2(TBL_DEPTH);
    localparam int TBL_ADDR_LSB = 4;

    typedef enum logic [KIND_W-1:0] {
        KIND_NONE = 2'd0,
        KIND_2B   = 2'd1,
        KIND_4B   = 2'd2,
        KIND_6B   = 2'd3
    } kind_e;

    // container widths and phv layout
    localparam int W2B   = 16;
    localparam int W4B   = 32;
    localparam int W6B   = 48;
    localparam int VAL_W = W6B;
    localparam int PHV_W = VLAN_W + NUM_CONT * (W2B + W4B + W6B);

    // control beat fields
    localparam int MOD_ID_LSB     = 368;
    localparam int MOD_ID_W       = 8;
    localparam int CTRL_FLAG_LSB  = 320;
    localparam int CTRL_FLAG_W    = 16;
    localparam int CTRL_INDEX_LSB = 384;
    localparam int CTRL_INDEX_W   = 8;
    localparam logic [CTRL_FLAG_W-1:0] CTRL_FLAG = 16'hf2f1;

endpackage

// ==== parser_sva.sv ====
module parser_sva import parser_pkg::*; (
    input  logic               axis_clk,
    input  logic               aresetn,
    input  logic               pkt_start_i,
    input  logic               phv_valid_i,
    input  logic [DATA_W-1:0]  c_m_tdata_i,
    input  logic [USER_W-1:0]  c_m_tuser_i,
    input  logic [KEEP_W-1:0]  c_m_tkeep_i,
    input  logic               c_m_tvalid_i,
    input  logic               c_m_tlast_i
);

    phv_pulse: assert property (@(posedge axis_clk) disable iff (!aresetn)
        phv_valid_i |=> !phv_valid_i)
        else $error("phv_valid_o stayed high for two cycles");

    // three edges from the first beat to the container write
    phv_after_start: assert property (@(posedge axis_clk) disable iff (!aresetn)
        pkt_start_i |=> ##3 phv_valid_i)
        else $error("phv_valid_o did not follow the packet start by 3 cycles");

    phv_from_start: assert property (@(posedge axis_clk) disable iff (!aresetn)
        phv_valid_i |-> $past(pkt_start_i, 4))
        else $error("phv_valid_o without a packet start 3 cycles before");

    ctrl_out_reset: assert property (@(posedge axis_clk)
        !aresetn |-> (!c_m_tvalid_i && !c_m_tlast_i && c_m_tdata_i == '0
                      && c_m_tuser_i == '0 && c_m_tkeep_i == '0))
        else $error("control outputs not low during reset");

endmodule

bind parser_top parser_sva i_parser_sva (
    .axis_clk     (axis_clk),
    .aresetn      (aresetn),
    .pkt_start_i  (pkt_start),
    .phv_valid_i  (phv_valid_o),
    .c_m_tdata_i  (c_m_axis_tdata_o),
    .c_m_tuser_i  (c_m_axis_tuser_o),
    .c_m_tkeep_i  (c_m_axis_tkeep_o),
    .c_m_tvalid_i (c_m_axis_tvalid_o),
    .c_m_tlast_i  (c_m_axis_tlast_o)
);

// ==== parser_top.sv ====
module parser_top import parser_pkg::*; #(
    parameter logic [2:0] PARSER_ID = 3'd0
) (
    input  logic                 axis_clk,
    input  logic                 aresetn,

    // data stream
    input  logic [DATA_W-1:0]    s_axis_tdata_i,
    input  logic                 s_axis_tvalid_i,
    input  logic                 s_axis_tlast_i,

    output logic                 phv_valid_o,
    output logic [PHV_W-1:0]     phv_o,

    // control stream in
    input  logic [DATA_W-1:0]    c_s_axis_tdata_i,
    input  logic [USER_W-1:0]    c_s_axis_tuser_i,
    input  logic [KEEP_W-1:0]    c_s_axis_tkeep_i,
    input  logic                 c_s_axis_tvalid_i,
    input  logic                 c_s_axis_tlast_i,

    // control stream out
    output logic [DATA_W-1:0]    c_m_axis_tdata_o,
    output logic [USER_W-1:0]    c_m_axis_tuser_o,
    output logic [KEEP_W-1:0]    c_m_axis_tkeep_o,
    output logic                 c_m_axis_tvalid_o,
    output logic                 c_m_axis_tlast_o
);

    logic                              pkt_start;
    logic [HDR_W-1:0]                  hdr;
    logic [VLAN_W-1:0]                 vlan_id;
    logic [ENTRY_W-1:0]                rd_entry;
    logic                              tbl_wr_en;
    logic [TBL_AW-1:0]                 tbl_wr_addr;
    logic [ENTRY_W-1:0]                tbl_wr_data;
    logic                              extract;
    logic [NUM_SLOTS-1:0][VAL_W-1:0]   slot_val;
    kind_e [NUM_SLOTS-1:0]             slot_kind;
    logic [NUM_SLOTS-1:0][IDX_W-1:0]   slot_idx;

    hdr_capture i_hdr_capture (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .pkt_start_o     (pkt_start),
        .hdr_o           (hdr),
        .vlan_id_o       (vlan_id)
    );

    parse_act_ram i_parse_act_ram (
        .axis_clk  (axis_clk),
        .aresetn   (aresetn),
        .wr_en_i   (tbl_wr_en),
        .wr_addr_i (tbl_wr_addr),
        .wr_data_i (tbl_wr_data),
        .rd_addr_i (vlan_id[TBL_ADDR_LSB +: TBL_AW]),
        .rd_data_o (rd_entry)
    );

    parse_ctrl #(
        .PARSER_ID (PARSER_ID)
    ) i_parse_ctrl (
        .axis_clk          (axis_clk),
        .aresetn           (aresetn),
        .c_s_axis_tdata_i  (c_s_axis_tdata_i),
        .c_s_axis_tuser_i  (c_s_axis_tuser_i),
        .c_s_axis_tkeep_i  (c_s_axis_tkeep_i),
        .c_s_axis_tvalid_i (c_s_axis_tvalid_i),
        .c_s_axis_tlast_i  (c_s_axis_tlast_i),
        .c_m_axis_tdata_o  (c_m_axis_tdata_o),
        .c_m_axis_tuser_o  (c_m_axis_tuser_o),
        .c_m_axis_tkeep_o  (c_m_axis_tkeep_o),
        .c_m_axis_tvalid_o (c_m_axis_tvalid_o),
        .c_m_axis_tlast_o  (c_m_axis_tlast_o),
        .tbl_wr_en_o       (tbl_wr_en),
        .tbl_wr_addr_o     (tbl_wr_addr),
        .tbl_wr_data_o     (tbl_wr_data)
    );

    // one extractor per slot, slot 0 from the top of the entry
    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
        field_extractor i_field_extractor (
            .axis_clk  (axis_clk),
            .aresetn   (aresetn),
            .hdr_i     (hdr),
            .action_i  (rd_entry[ENTRY_W-1-g*ACT_W -: ACT_W]),
            .extract_i (extract),
            .val_o     (slot_val[g]),
            .kind_o    (slot_kind[g]),
            .index_o   (slot_idx[g])
        );
    end

    phv_builder i_phv_builder (
        .axis_clk    (axis_clk),
        .aresetn     (aresetn),
        .pkt_start_i (pkt_start),
        .vlan_id_i   (vlan_id),
        .slot_val_i  (slot_val),
        .slot_kind_i (slot_kind),
        .slot_idx_i  (slot_idx),
        .extract_o   (extract),
        .phv_valid_o (phv_valid_o),
        .phv_o       (phv_o)
    );

endmodule

// ==== phv_builder.sv ====
module phv_builder import parser_pkg::*; (
    input  logic                             axis_clk,
    input  logic                             aresetn,
    input  logic                             pkt_start_i,
    input  logic [VLAN_W-1:0]                vlan_id_i,
    input  logic [NUM_SLOTS-1:0][VAL_W-1:0]  slot_val_i,
    input  kind_e [NUM_SLOTS-1:0]            slot_kind_i,
    input  logic [NUM_SLOTS-1:0][IDX_W-1:0]  slot_idx_i,
    output logic                             extract_o,
    output logic                             phv_valid_o,
    output logic [PHV_W-1:0]                 phv_o
);

    localparam int P2_LSB = VLAN_W;
    localparam int P4_LSB = P2_LSB + NUM_CONT * W2B;
    localparam int P6_LSB = P4_LSB + NUM_CONT * W4B;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT1,
        S_WAIT2,
        S_PHVGEN
    } state_e;

    state_e          state;
    logic [W2B-1:0]  cont_2b [NUM_CONT];
    logic [W4B-1:0]  cont_4b [NUM_CONT];
    logic [W6B-1:0]  cont_6b [NUM_CONT];

    // reverse the low nbytes bytes of v
    function automatic logic [VAL_W-1:0] byte_rev(input logic [VAL_W-1:0] v, input int nbytes);
        logic [VAL_W-1:0] r;
        r = '0;
        for (int k = 0; k < nbytes; k++) begin
            r[8*k +: 8] = v[8*(nbytes-1-k) +: 8];
        end
        return r;
    endfunction

    // table entry and header are stable by wait2
    assign extract_o = (state == S_WAIT2);

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= S_IDLE;
            phv_valid_o <= 1'b0;
            for (int c = 0; c < NUM_CONT; c++) begin
                cont_2b[c] <= '0;
                cont_4b[c] <= '0;
                cont_6b[c] <= '0;
            end
        end else begin
            phv_valid_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (pkt_start_i) begin
                        for (int c = 0; c < NUM_CONT; c++) begin
                            cont_2b[c] <= '0;
                            cont_4b[c] <= '0;
                            cont_6b[c] <= '0;
                        end
                        state <= S_WAIT1;
                    end
                end
                S_WAIT1: state <= S_WAIT2;
                S_WAIT2: state <= S_PHVGEN;
                S_PHVGEN: begin
                    // ascending order, so the last slot on a container wins
                    for (int s = 0; s < NUM_SLOTS; s++) begin
                        case (slot_kind_i[s])
                            KIND_2B: cont_2b[slot_idx_i[s]] <= slot_val_i[s][W2B-1:0];
                            KIND_4B: cont_4b[slot_idx_i[s]] <= slot_val_i[s][W4B-1:0];
                            KIND_6B: cont_6b[slot_idx_i[s]] <= slot_val_i[s][W6B-1:0];
                            default: ;
                        endcase
                    end
                    phv_valid_o <= 1'b1;
                    state       <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        logic [VAL_W-1:0] rev2;
        logic [VAL_W-1:0] rev4;
        logic [VAL_W-1:0] rev6;
        phv_o[VLAN_W-1:0] = vlan_id_i;
        for (int c = 0; c < NUM_CONT; c++) begin
            rev2 = byte_rev(VAL_W'(cont_2b[c]), W2B / 8);
            rev4 = byte_rev(VAL_W'(cont_4b[c]), W4B / 8);
            rev6 = byte_rev(cont_6b[c], W6B / 8);
            phv_o[P2_LSB + c*W2B +: W2B] = rev2[W2B-1:0];
            phv_o[P4_LSB + c*W4B +: W4B] = rev4[W4B-1:0];
            phv_o[P6_LSB + c*W6B +: W6B] = rev6[W6B-1:0];
        end
    end

endmodule

// ==== tb_parser.sv ====
module tb_parser import parser_pkg::*; ();

    localparam logic [2:0] DUT_ID = 3'd3;
    localparam int NUM_PKTS = 60;
    localparam int NUM_FWD  = 120;
    localparam int FWD_W    = DATA_W + USER_W + KEEP_W + 2;

    logic                axis_clk;
    logic                aresetn;
    logic [DATA_W-1:0]   s_axis_tdata;
    logic                s_axis_tvalid;
    logic                s_axis_tlast;
    logic                phv_valid;
    logic [PHV_W-1:0]    phv;
    logic [DATA_W-1:0]   c_s_axis_tdata;
    logic [USER_W-1:0]   c_s_axis_tuser;
    logic [KEEP_W-1:0]   c_s_axis_tkeep;
    logic                c_s_axis_tvalid;
    logic                c_s_axis_tlast;
    logic [DATA_W-1:0]   c_m_axis_tdata;
    logic [USER_W-1:0]   c_m_axis_tuser;
    logic [KEEP_W-1:0]   c_m_axis_tkeep;
    logic                c_m_axis_tvalid;
    logic                c_m_axis_tlast;

    logic [31:0]         lfsr_state;
    logic [ENTRY_W-1:0]  model_tbl [TBL_DEPTH];
    logic [ENTRY_W-1:0]  entry_q [$];
    logic [FWD_W-1:0]    fwd_q [$];

    parser_top #(
        .PARSER_ID (DUT_ID)
    ) i_dut (
        .axis_clk          (axis_clk),
        .aresetn           (aresetn),
        .s_axis_tdata_i    (s_axis_tdata),
        .s_axis_tvalid_i   (s_axis_tvalid),
        .s_axis_tlast_i    (s_axis_tlast),
        .phv_valid_o       (phv_valid),
        .phv_o             (phv),
        .c_s_axis_tdata_i  (c_s_axis_tdata),
        .c_s_axis_tuser_i  (c_s_axis_tuser),
        .c_s_axis_tkeep_i  (c_s_axis_tkeep),
        .c_s_axis_tvalid_i (c_s_axis_tvalid),
        .c_s_axis_tlast_i  (c_s_axis_tlast),
        .c_m_axis_tdata_o  (c_m_axis_tdata),
        .c_m_axis_tuser_o  (c_m_axis_tuser),
        .c_m_axis_tkeep_o  (c_m_axis_tkeep),
        .c_m_axis_tvalid_o (c_m_axis_tvalid),
        .c_m_axis_tlast_o  (c_m_axis_tlast)
    );

    initial axis_clk = 1'b0;
    always #2 axis_clk = ~axis_clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [1023:0] exp,
                               input logic [1023:0] act);
        assert (exp === act)
        else stop_on_error($sformatf("ERROR %s: expected %0h, actual %0h", name, exp, act));
    endtask

    // galois lfsr, one step per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h80200003 : 32'h0);
        return b;
    endfunction

    function automatic logic [DATA_W-1:0] rand_bits(input int n);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = next_bit();
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] avoid_cfg(input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] r;
        r = d;
        if (r[CTRL_FLAG_LSB +: CTRL_FLAG_W] == CTRL_FLAG) begin
            r[CTRL_FLAG_LSB] = ~r[CTRL_FLAG_LSB];
        end
        return r;
    endfunction

    function automatic logic [ACT_W-1:0] slot_act(input int off, input int kind, input int idx);
        return {4'h0, 3'(idx), 2'(kind), 7'(off)};
    endfunction

    // header bytes land byte reversed in their container
    function automatic logic [PHV_W-1:0] model_phv(input logic [HDR_W-1:0] hdr,
                                                   input logic [ENTRY_W-1:0] entry,
                                                   input logic [VLAN_W-1:0] vlan);
        logic [PHV_W-1:0] p;
        logic [ACT_W-1:0] act;
        int nb;
        int base;
        int off;
        int idx;
        p = '0;
        p[VLAN_W-1:0] = vlan;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            act = entry[ENTRY_W-1-s*ACT_W -: ACT_W];
            off = act[6:0];
            idx = act[11:9];
            nb  = 2 * act[8:7];
            case (act[8:7])
                2'd1: base = 12 + idx * 16;
                2'd2: base = 12 + 128 + idx * 32;
                default: base = 12 + 128 + 256 + idx * 48;
            endcase
            for (int k = 0; k < nb; k++) begin
                p[base + 8*(nb-1-k) +: 8] = (off + k < 128) ? hdr[8*(off+k) +: 8] : 8'h00;
            end
        end
        return p;
    endfunction

    task automatic drive_ctrl(input logic [DATA_W-1:0] data, input logic [USER_W-1:0] user,
                              input logic [KEEP_W-1:0] keep, input logic valid,
                              input logic last, input logic fwd);
        logic [FWD_W-1:0] exp;
        c_s_axis_tdata  = data;
        c_s_axis_tuser  = user;
        c_s_axis_tkeep  = keep;
        c_s_axis_tvalid = valid;
        c_s_axis_tlast  = last;
        fwd_q.push_back(fwd ? {valid, last, keep, user, data} : '0);
        @(posedge axis_clk);
        #1;
        exp = fwd_q.pop_front();
        check_value("fwd_tvalid", exp[FWD_W-1], c_m_axis_tvalid);
        if (exp[FWD_W-1]) begin
            check_value("fwd_beat", exp, {c_m_axis_tvalid, c_m_axis_tlast, c_m_axis_tkeep,
                                          c_m_axis_tuser, c_m_axis_tdata});
        end
    endtask

    task automatic ctrl_idle();
        drive_ctrl('0, '0, '0, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic send_fwd(input int n);
        logic [DATA_W-1:0] d;
        logic [7:0] id;
        for (int i = 0; i < n; i++) begin
            d = avoid_cfg(rand_bits(DATA_W));
            // config flag with a foreign module id
            if (next_bit()) begin
                id = 8'(rand_bits(8));
                if (id[2:0] == DUT_ID) begin
                    id[0] = ~id[0];
                end
                d[CTRL_FLAG_LSB +: CTRL_FLAG_W] = CTRL_FLAG;
                d[MOD_ID_LSB +: MOD_ID_W] = id;
            end
            drive_ctrl(d, USER_W'(rand_bits(USER_W)), KEEP_W'(rand_bits(KEEP_W)),
                       next_bit() | next_bit(), next_bit(), 1'b1);
        end
    endtask

    // header beat, then one beat per queued entry
    task automatic send_cfg(input logic [7:0] mod_id, input logic [7:0] start);
        logic [DATA_W-1:0] d;
        logic [ENTRY_W-1:0] e;
        logic hit;
        int n;
        hit = (mod_id[2:0] == DUT_ID);
        n = entry_q.size();
        d = rand_bits(DATA_W);
        d[CTRL_FLAG_LSB +: CTRL_FLAG_W] = CTRL_FLAG;
        d[MOD_ID_LSB +: MOD_ID_W] = mod_id;
        d[CTRL_INDEX_LSB +: CTRL_INDEX_W] = start;
        drive_ctrl(d, USER_W'(rand_bits(USER_W)), KEEP_W'(rand_bits(KEEP_W)), 1'b1, 1'b0, !hit);
        for (int i = 0; i < n; i++) begin
            e = entry_q.pop_front();
            d = avoid_cfg(rand_bits(DATA_W));
            for (int b = 0; b < 20; b++) begin
                d[8*b +: 8] = e[ENTRY_W-1-8*b -: 8];
            end
            drive_ctrl(d, USER_W'(rand_bits(USER_W)), KEEP_W'(rand_bits(KEEP_W)), 1'b1,
                       i == n - 1, !hit);
            if (hit) begin
                model_tbl[4'(start + i)] = e;
            end
        end
        ctrl_idle();
        ctrl_idle();
    endtask

    task automatic send_pkt(input int nbeats, input logic [VLAN_W-1:0] vlan);
        logic [DATA_W-1:0] beat [3];
        logic [HDR_W-1:0] hdr;
        logic [PHV_W-1:0] exp;
        logic found;
        int t;
        for (int b = 0; b < 3; b++) begin
            beat[b] = rand_bits(DATA_W);
        end
        beat[0][VLAN_LSB +: VLAN_W] = vlan;
        hdr[DATA_W-1:0] = beat[0];
        hdr[HDR_W-1:DATA_W] = (nbeats > 1) ? beat[1] : '0;
        exp = model_phv(hdr, model_tbl[vlan[7:4]], vlan);
        found = 1'b0;
        t = 0;
        while (!found) begin
            s_axis_tdata  = (t < nbeats) ? beat[t] : '0;
            s_axis_tvalid = (t < nbeats);
            s_axis_tlast  = (t == nbeats - 1);
            @(posedge axis_clk);
            #1;
            if (phv_valid) begin
                check_value("phv_latency", 3, t);
                check_value("phv", exp, phv);
                found = 1'b1;
            end else if (t >= 10) begin
                stop_on_error("phv_valid_o never rose after the first beat");
            end
            t++;
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        repeat (6) @(posedge axis_clk);
        #1;
    endtask

    initial begin : watchdog
        repeat ((NUM_PKTS + 4) * 20 + 2000) @(posedge axis_clk);
        stop_on_error("timeout: the test sequence did not finish in time");
    end

    initial begin
        logic [ENTRY_W-1:0] e;
        logic [VLAN_W-1:0] vlan;
        int r;
        lfsr_state      = 32'h89f6;
        aresetn         = 1'b1;
        s_axis_tdata    = '0;
        s_axis_tvalid   = 1'b0;
        s_axis_tlast    = 1'b0;
        c_s_axis_tdata  = '0;
        c_s_axis_tuser  = '0;
        c_s_axis_tkeep  = '0;
        c_s_axis_tvalid = 1'b0;
        c_s_axis_tlast  = 1'b0;
        for (int i = 0; i < TBL_DEPTH; i++) begin
            model_tbl[i] = '0;
        end
        #1 aresetn = 1'b0;
        repeat (10) @(posedge axis_clk);
        #1 aresetn = 1'b1;

        send_fwd(NUM_FWD);
        ctrl_idle();

        // whole table from a random start, then a foreign id
        for (int i = 0; i < TBL_DEPTH; i++) begin
            entry_q.push_back(ENTRY_W'(rand_bits(ENTRY_W)));
        end
        send_cfg({5'(rand_bits(5)), 3'd3}, 8'(rand_bits(8)));
        for (int i = 0; i < 4; i++) begin
            entry_q.push_back(ENTRY_W'(rand_bits(ENTRY_W)));
        end
        send_cfg({5'(rand_bits(5)), 3'd2}, 8'(rand_bits(8)));

        // slots 0 and 3 share a 2-byte container
        e = '0;
        e[ENTRY_W-1 -: ACT_W]           = slot_act(10, 1, 5);
        e[ENTRY_W-1-3*ACT_W -: ACT_W]   = slot_act(20, 1, 5);
        e[ENTRY_W-1-7*ACT_W -: ACT_W]   = slot_act(127, 3, 2);
        e[ENTRY_W-1-9*ACT_W -: ACT_W]   = slot_act(100, 2, 1);
        entry_q.push_back(e);
        send_cfg(8'h03, 8'd3);
        // fields across the beat boundary and the header end
        e = '0;
        e[ENTRY_W-1 -: ACT_W]           = slot_act(60, 3, 0);
        e[ENTRY_W-1-ACT_W -: ACT_W]     = slot_act(126, 2, 7);
        e[ENTRY_W-1-5*ACT_W -: ACT_W]   = slot_act(63, 1, 4);
        entry_q.push_back(e);
        send_cfg(8'hfb, 8'd9);

        vlan = 12'(rand_bits(12));
        vlan[7:4] = 4'd3;
        send_pkt(2, vlan);
        send_pkt(1, vlan);
        vlan[7:4] = 4'd9;
        send_pkt(1, vlan);
        send_pkt(2, vlan);

        for (int p = 0; p < NUM_PKTS; p++) begin
            r = int'(rand_bits(2));
            send_pkt((r == 0) ? 1 : (r == 3) ? 3 : 2, 12'(rand_bits(12)));
        end

        $display("All tests passed!");
        $finish;
    end

endmodule
